// ==== common/lsu_defines.svh ====
// Widths, RAM geometry and RV32 funct3 codes shared by the load/store unit
// RAM depth and word address bits must agree (2**LSU_RAM_AW == LSU_RAM_WORDS)
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

`define LSU_XLEN 32

// Data RAM, word addressed
`define LSU_RAM_WORDS 256
`define LSU_RAM_AW 8

// Store funct3
`define RISCV_FUNCT3_SB 3'd0
`define RISCV_FUNCT3_SH 3'd1
`define RISCV_FUNCT3_SW 3'd2

// Load funct3
`define RISCV_FUNCT3_LB 3'd0
`define RISCV_FUNCT3_LH 3'd1
`define RISCV_FUNCT3_LW 3'd2
`define RISCV_FUNCT3_LBU 3'd4
`define RISCV_FUNCT3_LHU 3'd5

`endif

// ==== common/lsu_pkg.sv ====
// Types shared by the load/store unit
// Word width follows LSU_XLEN from the defines header
`include "lsu_defines.svh"

package lsu_pkg;

  // One data or address word
  typedef logic [`LSU_XLEN-1:0] word_t;

  // Access size, taken from funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

endpackage

// ==== rtl/lsu_store_align.sv ====
// Places store data on its byte lanes and builds the byte select
// Purely combinational, a load gives an all-zero select
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_store_align
  import lsu_pkg::*;
(
  input  logic       store,
  input  logic [2:0] funct3,
  input  word_t      wdata,
  input  logic [1:0] addr_low,
  output word_t      lane_data,
  output logic [3:0] lane_sel
);

  word_t      byte_data;
  word_t      half_data;
  logic [3:0] byte_sel;
  logic [3:0] half_sel;

  always_comb begin
    case (addr_low)
      2'b00: byte_data = {24'b0, wdata[7:0]};
      2'b01: byte_data = {16'b0, wdata[7:0], 8'b0};
      2'b10: byte_data = {8'b0, wdata[7:0], 16'b0};
      default: byte_data = {wdata[7:0], 24'b0};
    endcase
    byte_sel = {3'b000, store} << addr_low;
  end

  always_comb begin
    if (addr_low[1]) begin
      half_data = {wdata[15:0], 16'b0}; // Upper half
      half_sel  = {{2{store}}, 2'b00};
    end else begin
      half_data = {16'b0, wdata[15:0]};
      half_sel  = {2'b00, {2{store}}};
    end
  end

  always_comb begin
    case (funct3)
      `RISCV_FUNCT3_SB: begin
        lane_data = byte_data;
        lane_sel  = byte_sel;
      end
      `RISCV_FUNCT3_SH: begin
        lane_data = half_data;
        lane_sel  = half_sel;
      end
      default: begin // SW and anything else
        lane_data = wdata;
        lane_sel  = {4{store}};
      end
    endcase
  end

endmodule

// ==== rtl/lsu_decode.sv ====
// Accepts one command at a time and holds its fields until the next one
// cmd_ready stays low from acceptance until the cycle after the response
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_decode
  import lsu_pkg::*;
(
  input  logic      clock,
  input  logic      rst_n,
  input  logic      cmd_valid,
  input  logic      cmd_store,
  input  logic [2:0] cmd_funct3,
  input  word_t     cmd_base,
  input  word_t     cmd_offset,
  input  word_t     cmd_wdata,
  input  logic      done,
  output logic      cmd_ready,
  output logic      go,
  output word_t     addr,
  output lsu_size_e size,
  output logic      sign,
  output logic      store,
  output word_t     wdata,
  output logic [2:0] funct3,
  output logic      misaligned
);

  logic      busy;
  logic      busy_next;
  logic      done_d;
  logic      accept;
  word_t     ea;
  lsu_size_e size_d;
  logic      misaligned_d;

  assign accept = cmd_valid && cmd_ready;
  assign ea     = cmd_base + cmd_offset;

  always_comb begin
    case (cmd_funct3)
      `RISCV_FUNCT3_LB, `RISCV_FUNCT3_LBU: size_d = SIZE_BYTE;
      `RISCV_FUNCT3_LH, `RISCV_FUNCT3_LHU: size_d = SIZE_HALF;
      default:                             size_d = SIZE_WORD;
    endcase
    misaligned_d = ((size_d == SIZE_HALF) && ea[0]) ||
                   ((size_d == SIZE_WORD) && (ea[1:0] != 2'b00));
  end

  // Busy ends one cycle after done so ready follows the response
  assign busy_next = accept ? 1'b1 : (done_d ? 1'b0 : busy);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      done_d    <= 1'b0;
      cmd_ready <= 1'b0;
      go        <= 1'b0;
    end else begin
      busy      <= busy_next;
      done_d    <= done;
      cmd_ready <= !busy_next;
      go        <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr       <= ea;
      size       <= size_d;
      sign       <= !cmd_store && !cmd_funct3[2] && (size_d != SIZE_WORD);
      store      <= cmd_store;
      wdata      <= cmd_wdata;
      funct3     <= cmd_funct3;
      misaligned <= misaligned_d;
    end
  end

  // Done only arrives for a command in flight
  a_done_when_busy: assert property (@(posedge clock) disable iff (!rst_n)
    done |-> busy);

endmodule

// ==== rtl/lsu_wb_master.sv ====
// Runs one Wishbone classic cycle per aligned command, none when misaligned
// Read data is valid on rdata only in the cycle done is high
`timescale 1ns/10ps

module lsu_wb_master
  import lsu_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       go,
  input  logic       misaligned,
  input  logic       store,
  input  logic [2:0] funct3,
  input  word_t      addr,
  input  word_t      wdata,
  input  logic       wb_ack,
  input  word_t      wb_dat_r,
  output logic       wb_cyc,
  output logic       wb_stb,
  output logic       wb_we,
  output word_t      wb_adr,
  output logic [3:0] wb_sel,
  output word_t      wb_dat_w,
  output logic       done,
  output word_t      rdata,
  output logic       skip
);

  typedef enum logic {
    IDLE,
    BUS
  } state_e;

  state_e     state;
  logic       start;
  logic       finish;
  word_t      lane_data;
  logic [3:0] lane_sel;

  lsu_store_align lsu_store_align_inst (
    .store     (store),
    .funct3    (funct3),
    .wdata     (wdata),
    .addr_low  (addr[1:0]),
    .lane_data (lane_data),
    .lane_sel  (lane_sel)
  );

  assign start  = (state == IDLE) && go && !misaligned;
  assign finish = (state == BUS) && wb_ack;
  assign skip   = (state == IDLE) && go && misaligned;
  assign done   = skip || finish;
  assign rdata  = finish ? wb_dat_r : '0; // Taken straight off the bus on ack

  assign wb_cyc = (state == BUS);
  assign wb_stb = (state == BUS);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      wb_we <= 1'b0;
    end else if (start) begin
      state <= BUS;
      wb_we <= store;
    end else if (finish) begin
      state <= IDLE;
      wb_we <= 1'b0;
    end
  end

  // Held for the whole cycle
  always_ff @(posedge clock) begin
    if (start) begin
      wb_adr   <= {addr[31:2], 2'b00};
      wb_sel   <= store ? lane_sel : 4'hf;
      wb_dat_w <= lane_data;
    end
  end

  a_go_when_idle: assert property (@(posedge clock) disable iff (!rst_n)
    go |-> state == IDLE);

  // Slave answers one cycle after stb is first seen
  a_ack_next_cycle: assert property (@(posedge clock) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_ack);

endmodule

// ==== rtl/lsu_load_extend.sv ====
// Extracts and extends load data, then registers the response
// Stores and misaligned commands respond with zero data
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_load_extend
  import lsu_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       done,
  input  logic       skip,
  input  logic       store,
  input  logic [2:0] funct3,
  input  logic [1:0] addr_low,
  input  word_t      rdata,
  output logic       rsp_valid,
  output word_t      rsp_rdata,
  output logic       rsp_misaligned
);

  logic [7:0]  byte_v;
  logic [15:0] half_v;
  word_t       ext;

  always_comb begin
    byte_v = rdata[8*addr_low +: 8];
    half_v = addr_low[1] ? rdata[31:16] : rdata[15:0];
    case (funct3)
      `RISCV_FUNCT3_LB:  ext = {{24{byte_v[7]}}, byte_v};
      `RISCV_FUNCT3_LBU: ext = {24'b0, byte_v};
      `RISCV_FUNCT3_LH:  ext = {{16{half_v[15]}}, half_v};
      `RISCV_FUNCT3_LHU: ext = {16'b0, half_v};
      default:           ext = rdata; // LW
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid      <= 1'b0;
      rsp_misaligned <= 1'b0;
    end else begin
      rsp_valid      <= done;
      rsp_misaligned <= done && skip;
    end
  end

  always_ff @(posedge clock) begin
    if (done) begin
      rsp_rdata <= (skip || store) ? '0 : ext;
    end
  end

endmodule

// ==== rtl/lsu_data_ram.sv ====
// Wishbone classic slave RAM, ack one cycle after stb is first seen
// Address bits above the word index are ignored, no error response
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_data_ram
  import lsu_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  word_t      wb_adr,
  input  logic [3:0] wb_sel,
  input  word_t      wb_dat_w,
  output logic       wb_ack,
  output word_t      wb_dat_r
);

  word_t                 mem [`LSU_RAM_WORDS];
  logic [`LSU_RAM_AW-1:0] word_idx;
  logic                  req;

  assign word_idx = wb_adr[`LSU_RAM_AW+1:2];
  assign req      = wb_cyc && wb_stb && !wb_ack; // No back-to-back ack

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (req && wb_we) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_sel[b]) begin
          mem[word_idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  always_ff @(posedge clock) begin
    if (req) begin
      wb_dat_r <= mem[word_idx];
    end
  end

  a_ack_in_cycle: assert property (@(posedge clock) disable iff (!rst_n)
    wb_ack |-> wb_cyc);

endmodule

// ==== rtl/lsu_top.sv ====
// Load/store unit with its on-chip data RAM
// Issuer must take rsp_valid in the cycle it is high
`timescale 1ns/10ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  logic       cmd_store,
  input  logic [2:0] cmd_funct3,
  input  word_t      cmd_base,
  input  word_t      cmd_offset,
  input  word_t      cmd_wdata,
  output logic       rsp_valid,
  output word_t      rsp_rdata,
  output logic       rsp_misaligned
);

  logic       go;
  logic       done;
  logic       skip;
  word_t      addr;
  lsu_size_e  size;
  logic       sign;
  logic       store;
  word_t      wdata;
  logic [2:0] funct3;
  logic       misaligned;
  word_t      rdata;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic       wb_ack;
  word_t      wb_adr;
  logic [3:0] wb_sel;
  word_t      wb_dat_w;
  word_t      wb_dat_r;

  lsu_decode lsu_decode_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_store  (cmd_store),
    .cmd_funct3 (cmd_funct3),
    .cmd_base   (cmd_base),
    .cmd_offset (cmd_offset),
    .cmd_wdata  (cmd_wdata),
    .done       (done),
    .cmd_ready  (cmd_ready),
    .go         (go),
    .addr       (addr),
    .size       (size),
    .sign       (sign),
    .store      (store),
    .wdata      (wdata),
    .funct3     (funct3),
    .misaligned (misaligned)
  );

  lsu_wb_master lsu_wb_master_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .go         (go),
    .misaligned (misaligned),
    .store      (store),
    .funct3     (funct3),
    .addr       (addr),
    .wdata      (wdata),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel),
    .wb_dat_w   (wb_dat_w),
    .done       (done),
    .rdata      (rdata),
    .skip       (skip)
  );

  lsu_load_extend lsu_load_extend_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .done           (done),
    .skip           (skip),
    .store          (store),
    .funct3         (funct3),
    .addr_low       (addr[1:0]),
    .rdata          (rdata),
    .rsp_valid      (rsp_valid),
    .rsp_rdata      (rsp_rdata),
    .rsp_misaligned (rsp_misaligned)
  );

  lsu_data_ram lsu_data_ram_inst (
    .clock    (clock),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
  );

  // End-to-end latency, 3 cycles aligned and 1 cycle misaligned
  a_aligned_latency: assert property (@(posedge clock) disable iff (!rst_n)
    go && !misaligned |-> ##3 rsp_valid && !rsp_misaligned);

  a_misaligned_latency: assert property (@(posedge clock) disable iff (!rst_n)
    go && misaligned |=> rsp_valid && rsp_misaligned);

  // Held decode fields still describe the command at response time
  a_signed_half: assert property (@(posedge clock) disable iff (!rst_n)
    rsp_valid && !rsp_misaligned && !store && sign && (size == SIZE_HALF)
    |-> rsp_rdata[31:16] == {16{rsp_rdata[15]}});

  a_unsigned_byte: assert property (@(posedge clock) disable iff (!rst_n)
    rsp_valid && !rsp_misaligned && !store && !sign && (size == SIZE_BYTE)
    |-> rsp_rdata[31:8] == 24'b0);

endmodule

// ==== tb/lsu_tb.sv ====
// Reads tb/lsu_golden.txt relative to the project root, so run from there
// Vectors build on each other and assume a RAM cleared by reset
`timescale 1ns/10ps

module lsu_tb;

  localparam int MAX_VEC        = 64;
  localparam int ALIGNED_LAT    = 3;
  localparam int MISALIGNED_LAT = 1;

  logic        clock;
  logic        rst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  logic        cmd_store;
  logic [2:0]  cmd_funct3;
  logic [31:0] cmd_base;
  logic [31:0] cmd_offset;
  logic [31:0] cmd_wdata;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;
  logic        rsp_misaligned;

  logic        vec_store  [MAX_VEC];
  logic [2:0]  vec_funct3 [MAX_VEC];
  logic [31:0] vec_base   [MAX_VEC];
  logic [31:0] vec_offset [MAX_VEC];
  logic [31:0] vec_wdata  [MAX_VEC];
  logic [31:0] vec_rdata  [MAX_VEC];
  logic        vec_mis    [MAX_VEC];
  int          num_vec;
  logic        vectors_loaded;
  logic [31:0] rng;
  logic [1:0]  gap;
  int          checks_done;

  lsu_top lsu_top_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_store      (cmd_store),
    .cmd_funct3     (cmd_funct3),
    .cmd_base       (cmd_base),
    .cmd_offset     (cmd_offset),
    .cmd_wdata      (cmd_wdata),
    .rsp_valid      (rsp_valid),
    .rsp_rdata      (rsp_rdata),
    .rsp_misaligned (rsp_misaligned)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks_done++;
    if (expected !== actual) begin
      abort_run($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          r;
    int          n;
    string       line;
    logic [31:0] field [7];
    fd = $fopen("tb/lsu_golden.txt", "r");
    if (fd == 0) abort_run("cannot open tb/lsu_golden.txt, run from the project root");
    num_vec = 0;
    r = $fgets(line, fd);
    while (r != 0) begin
      if (line.len() > 1 && line[0] != "#") begin // Skip comments and blank lines
        n = $sscanf(line, "%h %h %h %h %h %h %h", field[0], field[1], field[2],
                    field[3], field[4], field[5], field[6]);
        if (n != 7) abort_run($sformatf("malformed vector line: %s", line));
        if (num_vec >= MAX_VEC) abort_run("too many vectors in the golden file");
        vec_store[num_vec]  = field[0][0];
        vec_funct3[num_vec] = field[1][2:0];
        vec_base[num_vec]   = field[2];
        vec_offset[num_vec] = field[3];
        vec_wdata[num_vec]  = field[4];
        vec_rdata[num_vec]  = field[5];
        vec_mis[num_vec]    = field[6][0];
        num_vec++;
      end
      r = $fgets(line, fd);
    end
    $fclose(fd);
    if (num_vec == 0) abort_run("the golden file holds no vectors");
    vectors_loaded = 1'b1;
  endtask

  task automatic run_command(input int idx);
    int    latency;
    int    wait_cycles;
    int    exp_lat;
    logic  rsp_seen;
    string tag;
    tag     = $sformatf("vector %0d", idx);
    exp_lat = vec_mis[idx] ? MISALIGNED_LAT : ALIGNED_LAT;
    wait_cycles = 0;
    while (!cmd_ready) begin
      @(negedge clock);
      wait_cycles++;
      if (wait_cycles > 8) abort_run($sformatf("%s: cmd_ready never went high", tag));
    end
    @(posedge clock);
    cmd_valid  <= 1'b1;
    cmd_store  <= vec_store[idx];
    cmd_funct3 <= vec_funct3[idx];
    cmd_base   <= vec_base[idx];
    cmd_offset <= vec_offset[idx];
    cmd_wdata  <= vec_wdata[idx];
    @(negedge clock);
    check_value({tag, " ready at issue"}, 32'd1, {31'b0, cmd_ready});
    @(posedge clock); // Acceptance edge
    cmd_valid <= 1'b0;
    latency  = 0;
    rsp_seen = 1'b0;
    // Counts edges after acceptance until the response shows
    while (!rsp_seen && latency < 8) begin
      @(negedge clock);
      check_value({tag, " ready while busy"}, 32'd0, {31'b0, cmd_ready});
      rsp_seen = rsp_valid;
      if (!rsp_seen) latency++;
    end
    if (!rsp_seen) abort_run($sformatf("%s got no response within 8 cycles", tag));
    check_value({tag, " latency"}, 32'(exp_lat), 32'(latency));
    check_value({tag, " misaligned"}, {31'b0, vec_mis[idx]}, {31'b0, rsp_misaligned});
    check_value({tag, " rdata"}, vec_rdata[idx], rsp_rdata);
    @(negedge clock);
    check_value({tag, " single response"}, 32'd0, {31'b0, rsp_valid});
    check_value({tag, " ready after response"}, 32'd1, {31'b0, cmd_ready});
  endtask

  initial begin
    rst_n          = 1'b0;
    cmd_valid      = 1'b0;
    cmd_store      = 1'b0;
    cmd_funct3     = 3'd0;
    cmd_base       = 32'd0;
    cmd_offset     = 32'd0;
    cmd_wdata      = 32'd0;
    vectors_loaded = 1'b0;
    rng            = 32'd58;
    checks_done    = 0;
    load_vectors();
    repeat (4) @(posedge clock);
    @(negedge clock);
    check_value("reset rsp_valid", 32'd0, {31'b0, rsp_valid});
    check_value("reset cmd_ready", 32'd0, {31'b0, cmd_ready});
    @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    for (int idx = 0; idx < num_vec; idx++) begin
      rng = lcg_next(rng);
      gap = rng[17:16]; // 0 to 3 idle cycles
      repeat (gap) begin
        @(negedge clock);
        check_value("idle rsp_valid", 32'd0, {31'b0, rsp_valid});
      end
      run_command(idx);
    end
    if (checks_done == 0) begin
      abort_run("no checks were run");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

  // Budget per vector covers the gap, issue, latency and the ready check
  initial begin
    wait (vectors_loaded);
    repeat (num_vec * (ALIGNED_LAT + 8) + 20) @(posedge clock);
    abort_run("the run timed out before all vectors finished");
  end

endmodule

// ==== project.f ====
+incdir+common
common/lsu_pkg.sv
rtl/lsu_store_align.sv
rtl/lsu_decode.sv
rtl/lsu_wb_master.sv
rtl/lsu_load_extend.sv
rtl/lsu_data_ram.sv
rtl/lsu_top.sv
tb/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
SIM_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(wildcard common/*.sv common/*.svh rtl/*.sv tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_DIR)/V$(TOP)

$(SIM_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(SIM_DIR)

run: build
	./$(SIM_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/10ps -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR)

// ==== tb/lsu_golden.txt ====
# store funct3 base offset wdata exp_rdata exp_misaligned, all hex
# exp_rdata is zero for stores and misaligned commands
1 2 00000100 00000004 deadbeef 00000000 0
0 2 00000100 00000004 00000000 deadbeef 0
0 2 00000100 00000008 00000000 00000000 0
1 0 00000210 fffffff0 aaaaaa11 00000000 0
1 0 00000200 00000001 bbbbbb22 00000000 0
1 0 00000200 00000002 cccccc33 00000000 0
1 0 00000203 00000000 dddddd44 00000000 0
0 2 00000200 00000000 00000000 44332211 0
1 1 00000300 00000000 12348765 00000000 0
1 1 00000300 00000002 00009abc 00000000 0
1 1 00000304 00000002 00007001 00000000 0
0 1 00000300 00000000 00000000 ffff8765 0
0 5 00000300 00000000 00000000 00008765 0
0 1 00000302 00000000 00000000 ffff9abc 0
0 5 00000302 00000000 00000000 00009abc 0
0 1 00000306 00000000 00000000 00007001 0
0 2 00000304 00000000 00000000 70010000 0
0 2 00000300 00000000 00000000 9abc8765 0
1 2 000000c0 00000000 80ff7f81 00000000 0
0 0 000000c0 00000000 00000000 ffffff81 0
0 4 000000c0 00000000 00000000 00000081 0
0 0 000000c0 00000001 00000000 0000007f 0
0 4 000000c0 00000001 00000000 0000007f 0
0 0 000000c0 00000002 00000000 ffffffff 0
0 4 000000c0 00000002 00000000 000000ff 0
0 0 000000c0 00000003 00000000 ffffff80 0
0 4 000000c0 00000003 00000000 00000080 0
0 1 00000300 00000001 00000000 00000000 1
0 5 00000300 00000003 00000000 00000000 1
1 1 00000300 00000003 00005555 00000000 1
0 2 00000100 00000006 00000000 00000000 1
1 2 00000100 00000005 0badf00d 00000000 1
0 2 00000300 00000000 00000000 9abc8765 0
0 2 00000100 00000004 00000000 deadbeef 0
